/* Bender.yml */
package:
  name: sound_meter

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - sound_meter_pkg.sv
      - mic3_spi_receiver.sv
      - peak_level_meter.sv
      - seven_segment_display.sv
      - board_specific_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - sound_meter_assertions.sv
      - tb_board_specific_top.sv

/* board_specific_top.sv */
// Board wrapper: pin polarity, MIC3 power pins, SPI receiver, peak meter and display
`timescale 1ns/100ps
`include "sound_meter_config.svh"

module board_specific_top (
    input  logic                      clk,
    input  logic                      arst_n,

    input  logic [`SM_W_KEY - 1:0]    key,      // Active low
    output logic [`SM_W_LED - 1:0]    led,      // Active low

    output logic [7:0]                seg,      // Active low, abcdefgh
    output logic [`SM_W_DIGIT - 1:0]  dig,      // Active low

    output logic                      mic_cs,
    output logic                      mic_sck,
    input  logic                      mic_sdo,
    output logic                      mic_gnd,
    output logic                      mic_vcc
);

    //--------------------------------------------------
    // Internal, all active high

    sound_meter_pkg::mic_sample_t    sample;
    sound_meter_pkg::display_drive_t drive;

    logic                      clear;
    logic [`SM_W_SAMPLE - 1:0] peak;
    logic [`SM_W_LED - 1:0]    led_bar;

    assign clear = ~ key [0];                     // Only key 0 is used

    //--------------------------------------------------
    // Blocks

    mic3_spi_receiver i_microphone (
        .clk    ( clk     ),
        .arst_n ( arst_n  ),
        .sdo    ( mic_sdo ),
        .cs     ( mic_cs  ),
        .sck    ( mic_sck ),
        .sample ( sample  )
    );

    peak_level_meter i_meter (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .sample  ( sample  ),
        .clear   ( clear   ),
        .peak    ( peak    ),
        .led_bar ( led_bar )
    );

    seven_segment_display i_display (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .peak   ( peak   ),
        .drive  ( drive  )
    );

    //--------------------------------------------------
    // Pins

    assign led = ~ led_bar;
    assign seg = ~ drive.abcdefgh;
    assign dig = ~ drive.digit;

    assign mic_gnd = 1'b0;                        // PMOD powered from the pins
    assign mic_vcc = 1'b1;

endmodule

/* mic3_spi_receiver.sv */
// SPI master for the PMOD MIC3: cs and sck framing, word capture and the sample strobe
`timescale 1ns/100ps
`include "sound_meter_config.svh"

module mic3_spi_receiver (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         sdo,
    output logic                         cs,
    output logic                         sck,
    output sound_meter_pkg::mic_sample_t sample
);

    localparam int W_CNT  = $clog2(`SM_FRAME_GAP + `SM_SCK_DIV);
    localparam int W_HALF = $clog2(2 * `SM_W_FRAME);

    localparam logic [W_CNT - 1:0]  GAP_LAST  = W_CNT'(`SM_FRAME_GAP - 1);
    localparam logic [W_CNT - 1:0]  DIV_LAST  = W_CNT'(`SM_SCK_DIV - 1);
    localparam logic [W_HALF - 1:0] HALF_LAST = W_HALF'(2 * `SM_W_FRAME - 1);
    localparam logic [W_HALF - 1:0] RISE_LAST = W_HALF'(2 * `SM_W_FRAME - 2);

    logic [W_CNT - 1:0]        cnt;        // Gap length or sck half period
    logic [W_HALF - 1:0]       half;       // Half period index inside the frame
    logic                      half_end;
    logic                      last_rise;  // The 16th rising sck edge just happened
    logic [`SM_W_FRAME - 1:0]  shift_reg;
    logic [`SM_W_SAMPLE - 1:0] value_q;
    logic                      valid_q;

    assign half_end = !cs && cnt == DIV_LAST;

    //--------------------------------------------------
    // Frame sequencer
    //
    // cs high for the gap, then 32 half periods of sck starting low.
    // sck rises at the end of every even half period.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cs        <= 1'b1;
            sck       <= 1'b0;
            cnt       <= '0;
            half      <= '0;
            last_rise <= 1'b0;
        end else begin
            last_rise <= half_end && half == RISE_LAST;

            if (cs) begin
                if (cnt == GAP_LAST) begin
                    cnt <= '0;
                    cs  <= 1'b0;                       // Start of frame
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else if (half_end) begin
                cnt <= '0;

                if (half == HALF_LAST) begin
                    half <= '0;
                    cs   <= 1'b1;                      // End of frame, sck back low
                    sck  <= 1'b0;
                end else begin
                    half <= half + 1'b1;
                    sck  <= ~ sck;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    //--------------------------------------------------
    // Capture, MSB first

    always_ff @(posedge clk) begin
        if (half_end && !sck)                          // Rising sck edge
            shift_reg <= { shift_reg [`SM_W_FRAME - 2:0], sdo };
    end

    always_ff @(posedge clk) begin
        if (last_rise)
            value_q <= shift_reg [`SM_W_SAMPLE - 1:0];  // Lead bits drop out here
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            valid_q <= 1'b0;
        else
            valid_q <= last_rise;                      // One clock after the last rise
    end

    assign sample = '{ value: value_q, valid: valid_q };

endmodule

/* peak_level_meter.sv */
// Peak meter: sample magnitude, peak hold, timed decay, clear and the LED bar
`timescale 1ns/100ps
`include "sound_meter_config.svh"

module peak_level_meter (
    input  logic                         clk,
    input  logic                         arst_n,
    input  sound_meter_pkg::mic_sample_t sample,
    input  logic                         clear,
    output logic [`SM_W_SAMPLE - 1:0]    peak,
    output logic [`SM_W_LED - 1:0]       led_bar
);

    localparam int W       = `SM_W_SAMPLE;
    localparam int W_DECAY = $clog2(`SM_DECAY_CYCLES);
    localparam int LED_LOG = 4;                        // LED 0 lights at 16

    localparam logic [W - 1:0]       MIDSCALE   = W'(1) << (W - 1);
    localparam logic [W - 1:0]       MAX_MAG    = MIDSCALE - 1'b1;
    localparam logic [W_DECAY - 1:0] DECAY_LAST = W_DECAY'(`SM_DECAY_CYCLES - 1);

    logic [W - 1:0]       magnitude;
    logic [W - 1:0]       peak_next;
    logic [W_DECAY - 1:0] decay_cnt;
    logic                 decay_tick;

    //--------------------------------------------------
    // Distance from midscale

    always_comb begin
        if (sample.value >= MIDSCALE)
            magnitude = sample.value - MIDSCALE;
        else if (sample.value == '0)
            magnitude = MAX_MAG;                       // 2048 below midscale saturates
        else
            magnitude = MIDSCALE - sample.value;
    end

    //--------------------------------------------------
    // Decay timer

    assign decay_tick = decay_cnt == DECAY_LAST;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            decay_cnt <= '0;
        else if (decay_tick)
            decay_cnt <= '0;
        else
            decay_cnt <= decay_cnt + 1'b1;
    end

    //--------------------------------------------------
    // Peak hold

    // A tick and a sample in the same cycle both count, clear overrides all
    always_comb begin
        peak_next = decay_tick ? peak >> 1 : peak;

        if (sample.valid && magnitude > peak_next)
            peak_next = magnitude;

        if (clear)
            peak_next = '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            peak <= '0;
        else
            peak <= peak_next;
    end

    //--------------------------------------------------
    // Thermometer bar, LED i at 2 ** (i + 4)

    always_comb begin
        for (int i = 0; i < `SM_W_LED; i++)
            led_bar [i] = int'(peak) >= (1 << (i + LED_LOG));
    end

endmodule

/* seven_segment_display.sv */
// Four-digit multiplexed display of the peak level in hex, with the segment decoder
`timescale 1ns/100ps
`include "sound_meter_config.svh"

module seven_segment_display (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [`SM_W_SAMPLE - 1:0]       peak,
    output sound_meter_pkg::display_drive_t drive
);

    localparam int W_SCAN = $clog2(`SM_SCAN_CYCLES);

    localparam logic [W_SCAN - 1:0] SCAN_LAST = W_SCAN'(`SM_SCAN_CYCLES - 1);

    logic [W_SCAN - 1:0]       scan_cnt;
    logic [`SM_W_DIGIT - 1:0]  digit_sel;
    logic [3:0]                nibble;
    logic                      blank;
    sound_meter_pkg::segment_t pattern;

    //--------------------------------------------------
    // Hex decoder, abcdefgh with the point always off

    function automatic sound_meter_pkg::segment_t hex_to_segments (input logic [3:0] hex);
        case (hex)
            4'h0: hex_to_segments = 8'b1111_1100;
            4'h1: hex_to_segments = 8'b0110_0000;
            4'h2: hex_to_segments = 8'b1101_1010;
            4'h3: hex_to_segments = 8'b1111_0010;
            4'h4: hex_to_segments = 8'b0110_0110;
            4'h5: hex_to_segments = 8'b1011_0110;
            4'h6: hex_to_segments = 8'b1011_1110;
            4'h7: hex_to_segments = 8'b1110_0000;
            4'h8: hex_to_segments = 8'b1111_1110;
            4'h9: hex_to_segments = 8'b1111_0110;
            4'ha: hex_to_segments = 8'b1110_1110;
            4'hb: hex_to_segments = 8'b0011_1110;  // Lower case b
            4'hc: hex_to_segments = 8'b1001_1100;
            4'hd: hex_to_segments = 8'b0111_1010;  // Lower case d
            4'he: hex_to_segments = 8'b1001_1110;
            default: hex_to_segments = 8'b1000_1110;
        endcase
    endfunction

    //--------------------------------------------------
    // Digit scan

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_cnt  <= '0;
            digit_sel <= `SM_W_DIGIT'(1);              // Digit 0 first
        end else if (scan_cnt == SCAN_LAST) begin
            scan_cnt  <= '0;
            digit_sel <= { digit_sel [`SM_W_DIGIT - 2:0], digit_sel [`SM_W_DIGIT - 1] };
        end else begin
            scan_cnt  <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        nibble = '0;
        blank  = 1'b1;                                 // Top digit stays dark

        if (digit_sel [0]) begin
            nibble = peak [3:0];
            blank  = 1'b0;
        end else if (digit_sel [1]) begin
            nibble = peak [7:4];
            blank  = 1'b0;
        end else if (digit_sel [2]) begin
            nibble = peak [11:8];
            blank  = 1'b0;
        end
    end

    assign pattern = blank ? '0 : hex_to_segments (nibble);

    assign drive = '{ abcdefgh: pattern, digit: digit_sel };

endmodule

/* sound_meter.f */
+incdir+.
sound_meter_pkg.sv
mic3_spi_receiver.sv
peak_level_meter.sv
seven_segment_display.sv
board_specific_top.sv
sound_meter_assertions.sv
tb_board_specific_top.sv

/* sound_meter_assertions.sv */
// SPI framing and sample strobe checks for the MIC3 receiver
`timescale 1ns/100ps
`include "sound_meter_config.svh"

module sound_meter_assertions (
    input logic                         clk,
    input logic                         arst_n,
    input logic                         cs,
    input logic                         sck,
    input sound_meter_pkg::mic_sample_t sample
);

    localparam int W_RISE = $clog2(`SM_W_FRAME + 1);

    logic                sck_q;
    logic [W_RISE - 1:0] rise_cnt;                // Rising sck edges while cs is low

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sck_q    <= 1'b0;
            rise_cnt <= '0;
        end else begin
            sck_q <= sck;
            if (cs)
                rise_cnt <= '0;
            else if (sck && !sck_q)
                rise_cnt <= rise_cnt + 1'b1;
        end
    end

    //--------------------------------------------------
    // Framing rules

    sck_low_while_idle: assert property (
        @(posedge clk) disable iff (!arst_n) cs |-> !sck
    ) else $error("sck is high while cs is high");

    valid_one_clock: assert property (
        @(posedge clk) disable iff (!arst_n) sample.valid |=> !sample.valid
    ) else $error("sample valid stayed high for more than one clock");

    sixteen_rises_per_frame: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(cs) |-> rise_cnt == W_RISE'(`SM_W_FRAME)
    ) else $error("cs-low period did not hold exactly 16 rising sck edges");

endmodule

/* sound_meter_config.svh */
// Sound meter build constants: clock, SPI framing, decay and scan timing, bus widths
`ifndef SOUND_METER_CONFIG_SVH
`define SOUND_METER_CONFIG_SVH

//--------------------------------------------------
// Clock and timing

`define SM_CLK_MHZ        25    // System clock, 40 ns period
`define SM_SCK_DIV        2     // System clocks per half period of sck
`define SM_FRAME_GAP      8     // Clocks with cs high between frames
`define SM_DECAY_CYCLES   4096  // Clocks between peak halvings
`define SM_SCAN_CYCLES    16    // Clocks each digit stays lit

//--------------------------------------------------
// Widths

`define SM_W_FRAME        16    // Bits per MIC3 SPI word
`define SM_W_SAMPLE       12    // ADC bits, the low end of the word
`define SM_W_KEY          4
`define SM_W_LED          8
`define SM_W_DIGIT        4

// The first four bits of each word carry no data
`define SM_W_LEAD         (`SM_W_FRAME - `SM_W_SAMPLE)

`endif

/* sound_meter_input.txt */
// Columns: 12-bit sample (hex), key clear flag, expected peak after the frame (hex)
// Midscale 800 is silence, magnitudes saturate at 7FF
800 0 000
850 0 050
7C0 0 050
900 0 100
6A3 0 15D
812 0 15D
000 0 7FF
001 0 7FF
FFF 0 7FF
A5A 1 000
823 0 023
7F0 0 023
C3B 0 43B
4E7 0 43B
900 1 000
B6D 0 36D
5AB 0 36D

/* sound_meter_pkg.sv */
// Sound meter types: microphone sample, segment pattern and display drive
`include "sound_meter_config.svh"

package sound_meter_pkg;

    //--------------------------------------------------
    // Microphone side

    typedef struct packed {
        logic [`SM_W_SAMPLE - 1:0] value;  // Offset binary, midscale is silence
        logic                      valid;  // One-cycle strobe
    } mic_sample_t;

    //--------------------------------------------------
    // Display side

    // Segment order a..g then the decimal point,
    // bit 7 is segment a, active high inside the design
    typedef logic [7:0] segment_t;

    typedef struct packed {
        segment_t                  abcdefgh;  // Pattern for the selected digit
        logic [`SM_W_DIGIT - 1:0]  digit;     // One-hot, digit 0 at bit 0
    } display_drive_t;

endpackage

/* tb_board_specific_top.sv */
// Testbench for the sound meter board top: clock, reset, MIC3 model, display decoder and checks
`timescale 1ns/100ps
`include "sound_meter_config.svh"

module tb_board_specific_top;

    localparam int CLK_HALF     = 20;
    localparam int MAX_LINES    = 64;
    localparam int SEED         = 57313;
    localparam int DECAY_STEPS  = 12;
    localparam int READ_CYCLES  = 3 * `SM_SCAN_CYCLES + 4;  // Sees digits 0 to 2 at any phase
    localparam int FRAME_CYCLES = `SM_W_FRAME * 2 * `SM_SCK_DIV + `SM_FRAME_GAP + 4;

    localparam logic [11:0] MIDSCALE = 12'h800;

    logic                     clk;
    logic                     arst_n;
    logic [`SM_W_KEY - 1:0]   key;
    logic [`SM_W_LED - 1:0]   led;
    logic [7:0]               seg;
    logic [`SM_W_DIGIT - 1:0] dig;
    logic                     mic_cs;
    logic                     mic_sck;
    logic                     mic_sdo;
    logic                     mic_gnd;
    logic                     mic_vcc;

    logic [11:0] sample_mem [MAX_LINES];
    logic        clear_mem  [MAX_LINES];
    logic [11:0] peak_mem   [MAX_LINES];
    int          n_lines = 0;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit  = 1_000_000_000;                   // Set once the data file is read

    // MIC3 model state
    int          frame_idx = 0;                   // Completed frames
    int          bit_idx;
    logic [15:0] word;
    logic        prev_cs  = 1'b1;
    logic        prev_sck = 1'b0;

    board_specific_top uut (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .key     ( key     ),
        .led     ( led     ),
        .seg     ( seg     ),
        .dig     ( dig     ),
        .mic_cs  ( mic_cs  ),
        .mic_sck ( mic_sck ),
        .mic_sdo ( mic_sdo ),
        .mic_gnd ( mic_gnd ),
        .mic_vcc ( mic_vcc )
    );

    bind mic3_spi_receiver sound_meter_assertions i_spi_checks (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cs     ( cs     ),
        .sck    ( sck    ),
        .sample ( sample )
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~ clk;

    //--------------------------------------------------
    // Cycle count and timeout

    always @(posedge clk) begin
        if (arst_n)
            cycles <= cycles + 1;
        if (arst_n && cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", limit);
            $display("Summary: %0d checks, %0d errors", checks, errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //--------------------------------------------------
    // MIC3 model that follows cs and sck as seen at each clock edge

    always @(posedge clk) begin
        if (arst_n) begin
            if (!mic_cs && prev_cs) begin                        // Frame start
                if (frame_idx < n_lines)
                    word = { 4'($urandom()), sample_mem [frame_idx] };
                else
                    word = { 4'($urandom()), MIDSCALE };         // Silence after the data
                mic_sdo <= word [15];
                bit_idx = 14;
            end else if (mic_cs && !prev_cs) begin               // Frame end
                key       <= '1;
                frame_idx = frame_idx + 1;
            end else if (!mic_cs && prev_sck && !mic_sck) begin  // sck fell
                mic_sdo <= word [bit_idx];
                // Clear overlaps the strobe but not the previous readout
                if (bit_idx == 0 && frame_idx < n_lines && clear_mem [frame_idx])
                    key [0] <= 1'b0;
                bit_idx = bit_idx - 1;
            end
            prev_cs  = mic_cs;
            prev_sck = mic_sck;
        end
    end

    //--------------------------------------------------
    // Reference rules and display decoding

    function automatic int magnitude (input int value);
        if (value >= 2048)
            return value - 2048;
        else if (2048 - value > 2047)
            return 2047;                                         // Saturates at the bottom
        else
            return 2048 - value;
    endfunction

    // The top set bit b of the peak lights LEDs 0 to b - 4
    function automatic logic [7:0] thermometer (input logic [11:0] peak);
        logic [7:0] bar;
        bar = '0;
        for (int b = 4; b < 12; b++)
            if (peak [b])
                bar = 8'((1 << (b - 3)) - 1);
        return bar;
    endfunction

    // Pattern is abcdefg plus the point and active high
    function automatic bit segments_to_hex (input logic [7:0] pattern, output logic [3:0] hex);
        segments_to_hex = 1'b1;
        hex             = 4'h0;
        case (pattern)
            8'b1111_1100: hex = 4'h0;
            8'b0110_0000: hex = 4'h1;
            8'b1101_1010: hex = 4'h2;
            8'b1111_0010: hex = 4'h3;
            8'b0110_0110: hex = 4'h4;
            8'b1011_0110: hex = 4'h5;
            8'b1011_1110: hex = 4'h6;
            8'b1110_0000: hex = 4'h7;
            8'b1111_1110: hex = 4'h8;
            8'b1111_0110: hex = 4'h9;
            8'b1110_1110: hex = 4'ha;
            8'b0011_1110: hex = 4'hb;
            8'b1001_1100: hex = 4'hc;
            8'b0111_1010: hex = 4'hd;
            8'b1001_1110: hex = 4'he;
            8'b1000_1110: hex = 4'hf;
            default:      segments_to_hex = 1'b0;
        endcase
    endfunction

    task automatic check_value (input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, got, expected);
        end
    endtask

    // Watches the scan long enough to catch every lit digit once
    task automatic read_display (output logic [11:0] value);
        logic [3:0] nibble [3];
        bit         seen   [3];
        logic [3:0] select;
        logic [3:0] hex;
        bit         valid_hex;
        int         idx;
        for (int d = 0; d < 3; d++) begin
            nibble [d] = 4'h0;
            seen [d]   = 1'b0;
        end
        for (int c = 0; c < READ_CYCLES; c++) begin
            @(posedge clk);
            select = ~ dig;
            idx    = 0;
            for (int d = 0; d < `SM_W_DIGIT; d++)
                if (select [d])
                    idx = d;
            assert ($countones(select) == 1) else begin
                errors++;
                $display("At %0t the digit select %b is not one-hot", $time, dig);
            end
            if (idx == 3) begin
                check_value("seg on digit 3", seg, 8'hff);      // Blank
            end else begin
                valid_hex = segments_to_hex(~ seg, hex);
                assert (valid_hex) else begin
                    errors++;
                    $display("At %0t the pattern %b on digit %0d is no hex digit",
                             $time, seg, idx);
                end
                nibble [idx] = hex;
                seen [idx]   = 1'b1;
            end
        end
        for (int d = 0; d < 3; d++)
            assert (seen [d]) else begin
                errors++;
                $display("Digit %0d was never selected during the readout", d);
            end
        value = { nibble [2], nibble [1], nibble [0] };
    endtask

    //--------------------------------------------------
    // Main sequence

    initial begin
        int          fd;
        string       line;
        int          s;
        int          k;
        int          p;
        int          running;
        logic [11:0] shown;
        logic [11:0] decayed;
        logic [7:0]  led_exp;

        arst_n  = 1'b0;
        key     = '1;
        mic_sdo = 1'b0;
        void'($urandom(SEED));

        fd = $fopen("sound_meter_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open sound_meter_input.txt, no frames were played");
        end else begin
            running = 0;
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%h %h %h", s, k, p) == 3) begin
                    sample_mem [n_lines] = s [11:0];
                    clear_mem [n_lines]  = k [0];
                    peak_mem [n_lines]   = p [11:0];
                    // Running maximum of the magnitudes that a clear zeroes
                    if (k != 0)
                        running = 0;
                    else if (magnitude(s) > running)
                        running = magnitude(s);
                    assert (running == p) else begin
                        errors++;
                        $display("Data line %0d expects peak %03h but the rule gives %03h",
                                 n_lines, p, running);
                    end
                    n_lines++;
                end
            end
            $fclose(fd);
        end
        limit = n_lines * FRAME_CYCLES + 3 * `SM_DECAY_CYCLES * 12 + 1000;

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        check_value("mic_cs", mic_cs, 1);
        check_value("mic_sck", mic_sck, 0);
        check_value("led", led, 8'hff);                          // All dark
        check_value("dig", dig, 4'b1110);
        check_value("mic_gnd", mic_gnd, 0);
        check_value("mic_vcc", mic_vcc, 1);

        for (int i = 0; i < n_lines; i++) begin
            wait (frame_idx > i);
            repeat (2) @(posedge clk);
            read_display(shown);
            check_value("peak display", shown, peak_mem [i]);
            led_exp = ~ thermometer(peak_mem [i]);
            check_value("led", led, led_exp);
        end

        if (n_lines > 0) begin
            decayed = peak_mem [n_lines - 1];
            shown   = decayed;
            for (int step = 1; step <= DECAY_STEPS; step++) begin
                decayed = decayed >> 1;                          // One halving per tick
                while (cycles < step * `SM_DECAY_CYCLES + 2)
                    @(posedge clk);
                read_display(shown);
                check_value("peak display", shown, decayed);
                led_exp = ~ thermometer(decayed);
                check_value("led", led, led_exp);
            end
            check_value("peak display after decay", shown, 0);
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
